//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_stage_tb \
    -f verilog.f -o mem_stage_sim > build.log 2>&1 \
    && ./obj_dir/mem_stage_sim | tee sim.log \
    || { echo "Build or run error, see build.log"; }

grep -q "TEST FAILED" sim.log 2>/dev/null && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log 2>/dev/null || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"

//--- verification/mem_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_tb import lsu_pkg::*; ();

    localparam int MEM_LATENCY = 3;
    localparam int RAM_WORDS   = 256;
    localparam int RAND_OPS    = 200;
    localparam int NUM_OPS     = 64 + 56 + 16 + 15 + 15 + 16 + RAND_OPS;
    localparam int WATCHDOG_NS = 40 * (NUM_OPS * (MEM_LATENCY + 4) + 8 + 100);

    logic      clk;
    logic      rst_n_i;
    ex_mem_t   ex_i;
    logic      stall_o;
    wb_t       wb_o;
    fwd_t      fwd_o;

    logic [31:0] lfsr;
    word_t       model_mem [64];
    logic        model_ll;
    wb_t         exp_q [$];
    string       name_q [$];
    wb_t         exp_head;
    logic        exp_avail;
    string       head_name;
    string       test_name;
    logic        drv_ce;
    fwd_t        drv_fwd;
    logic        acc_mem_q;
    logic        acc_plain_q;
    logic        acc_item_q;
    fwd_t        acc_fwd_q;

    mem_stage_top #(
        .MEM_LATENCY (MEM_LATENCY),
        .RAM_WORDS   (RAM_WORDS)
    ) UUT (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ex_i    (ex_i),
        .stall_o (stall_o),
        .wb_o    (wb_o),
        .fwd_o   (fwd_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t load_value(input mem_op_e op, input word_t w, input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{off, 3'b000} +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (op)
            OP_LD_B:  return {{24{b[7]}}, b};
            OP_LD_BU: return {24'h0, b};
            OP_LD_H:  return {{16{h[15]}}, h};
            OP_LD_HU: return {16'h0, h};
            default:  return w;
        endcase
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic refresh_head();
        exp_avail = exp_q.size() != 0;
        if (exp_avail) begin
            exp_head  = exp_q[0];
            head_name = name_q[0];
        end
    endtask

    // Drive one operation, update the model, wait until it is accepted
    task automatic issue(input mem_op_e op, input addr_t addr, input word_t data);
        ex_mem_t    e;
        wb_t        exp;
        logic       mis;
        logic [5:0] idx;
        idx = addr[7:2];
        mis = (op inside {OP_LD_H, OP_LD_HU, OP_ST_H} && addr[0])
              || (op inside {OP_LD_W, OP_ST_W, OP_LL, OP_SC} && addr[1:0] != 2'b00);
        e.valid   = 1'b1;
        e.op      = op;
        e.addr    = addr;
        e.reg2    = data;
        e.wreg    = !(op inside {OP_ST_B, OP_ST_H, OP_ST_W});
        e.waddr   = 5'(rand_bits(5));
        e.wdata   = rand_bits(32);
        exp.valid = 1'b1;
        exp.wreg  = e.wreg && !mis;
        exp.waddr = e.waddr;
        exp.wdata = e.wdata;
        exp.ale   = mis;
        drv_ce    = op != OP_NONE && !mis && (op != OP_SC || model_ll);
        drv_fwd.is_load = op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W,
                                     OP_LL, OP_SC};
        drv_fwd.wreg    = e.wreg && !mis;
        drv_fwd.waddr   = e.waddr;
        drv_fwd.wdata   = e.wdata;
        if (!mis) begin
            case (op)
                OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL: begin
                    exp.wdata = load_value(op, model_mem[idx], addr[1:0]);
                end
                OP_ST_B: model_mem[idx][{addr[1:0], 3'b000} +: 8] = data[7:0];
                OP_ST_H: model_mem[idx][{addr[1], 4'b0000} +: 16] = data[15:0];
                OP_ST_W: model_mem[idx] = data;
                OP_SC: begin
                    exp.wdata = {31'b0, model_ll};
                    if (model_ll) begin
                        model_mem[idx] = data;
                    end
                    model_ll = 1'b0;
                end
                default: begin
                end
            endcase
            if (op == OP_LL) begin
                model_ll = 1'b1;
            end
        end
        exp_q.push_back(exp);
        name_q.push_back(test_name);
        refresh_head();
        ex_i = e;
        @(negedge clk);
        while (stall_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        ex_i.valid = 1'b0;
    endtask

    // Acceptance record and retirement of checked writebacks
    always @(posedge clk) begin
        if (!rst_n_i) begin
            acc_mem_q   <= 1'b0;
            acc_plain_q <= 1'b0;
            acc_item_q  <= 1'b0;
            acc_fwd_q   <= '0;
        end else begin
            acc_mem_q   <= ex_i.valid && !stall_o && drv_ce;
            acc_plain_q <= ex_i.valid && !stall_o && !drv_ce;
            acc_item_q  <= ex_i.valid && !stall_o;
            acc_fwd_q   <= drv_fwd;
            if (wb_o.valid && exp_avail) begin
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
                refresh_head();
            end
        end
    end

    a_wb_match: assert property (@(negedge clk) disable iff (!rst_n_i)
        wb_o.valid |-> exp_avail && wb_o == exp_head)
        else begin
            if (!exp_avail) begin
                stop_on_error("A writeback arrived with no operation outstanding");
            end else begin
                stop_on_error($sformatf("[ERROR] %s: expected %h, actual %h",
                                        head_name, exp_head, wb_o));
            end
        end

    a_mem_stall: assert property (@(negedge clk) disable iff (!rst_n_i)
        acc_mem_q |-> stall_o)
        else stop_on_error("stall_o stayed low while a memory access was pending");

    a_plain_flow: assert property (@(negedge clk) disable iff (!rst_n_i)
        acc_plain_q |-> !stall_o)
        else stop_on_error("stall_o went high for an item without a memory access");

    a_fwd_match: assert property (@(negedge clk) disable iff (!rst_n_i)
        acc_item_q |-> fwd_o == acc_fwd_q)
        else stop_on_error($sformatf("[ERROR] %s: expected fwd %h, actual %h",
                                     test_name, acc_fwd_q, fwd_o));

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("Watchdog expired before all operations retired");
    end

    initial begin
        logic [5:0] idx;
        logic [1:0] off;
        logic [3:0] opv;
        int         waited;
        lfsr      = 32'he624;
        rst_n_i   = 1'b0;
        ex_i      = '0;
        drv_ce    = 1'b0;
        drv_fwd   = '0;
        model_ll  = 1'b0;
        exp_avail = 1'b0;
        exp_head  = '0;
        test_name = "fill";
        repeat (8) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        for (int i = 0; i < 64; i++) begin
            issue(OP_ST_W, {24'b0, 6'(i), 2'b00}, (32'(i) * 32'h0101_0101) ^ 32'hC3A5_5A3C);
        end
        test_name = "load_extend";
        for (int k = 0; k < 4; k++) begin
            idx = 6'(rand_bits(6));
            issue(OP_ST_W, {24'b0, idx, 2'b00}, (k == 0) ? 32'h80FF_7F01 : rand_bits(32));
            for (int o = 0; o < 4; o++) begin
                issue(OP_LD_B, {24'b0, idx, 2'(o)}, '0);
                issue(OP_LD_BU, {24'b0, idx, 2'(o)}, '0);
                if (o % 2 == 0) begin
                    issue(OP_LD_H, {24'b0, idx, 2'(o)}, '0);
                    issue(OP_LD_HU, {24'b0, idx, 2'(o)}, '0);
                end
            end
            issue(OP_LD_W, {24'b0, idx, 2'b00}, '0);
        end
        test_name = "partial_store";
        for (int k = 0; k < 4; k++) begin
            idx = 6'(rand_bits(6));
            off = 2'(rand_bits(2));
            issue(OP_ST_B, {24'b0, idx, off}, rand_bits(32));
            issue(OP_LD_W, {24'b0, idx, 2'b00}, '0);
            issue(OP_ST_H, {24'b0, idx, off[1], 1'b0}, rand_bits(32));
            issue(OP_LD_W, {24'b0, idx, 2'b00}, '0);
        end
        test_name = "ll_sc";
        for (int k = 0; k < 3; k++) begin
            idx = 6'(rand_bits(6));
            issue(OP_LL, {24'b0, idx, 2'b00}, '0);
            issue(OP_SC, {24'b0, idx, 2'b00}, rand_bits(32));
            issue(OP_LD_W, {24'b0, idx, 2'b00}, '0);
            issue(OP_SC, {24'b0, idx, 2'b00}, rand_bits(32));
            issue(OP_LD_W, {24'b0, idx, 2'b00}, '0);
        end
        test_name = "misaligned";
        for (int k = 0; k < 3; k++) begin
            idx = 6'(rand_bits(6));
            issue(OP_LD_H, {24'b0, idx, 2'b01}, '0);
            issue(OP_ST_H, {24'b0, idx, 2'b11}, rand_bits(32));
            issue(OP_LD_W, {24'b0, idx, 2'b10}, '0);
            issue(OP_ST_W, {24'b0, idx, 2'(k + 1)}, rand_bits(32));
            issue(OP_LD_W, {24'b0, idx, 2'b00}, '0);
        end
        test_name = "non_memory";
        for (int k = 0; k < 16; k++) begin
            issue(OP_NONE, rand_bits(32), rand_bits(32));
        end
        test_name = "random_mix";
        for (int k = 0; k < RAND_OPS; k++) begin
            opv = 4'(rand_bits(4) % 11);
            issue(mem_op_e'(opv), {24'b0, 8'(rand_bits(8))}, rand_bits(32));
        end
        waited = 0;
        while (exp_q.size() != 0 && waited < 4 * (MEM_LATENCY + 4)) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
        if (exp_q.size() != 0) begin
            stop_on_error("Some operations never produced a writeback");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/lsu_pkg.sv
verilog/mem_wait_timer.sv
verilog/dcache_ctrl.sv
verilog/data_ram.sv
verilog/mem1_stage.sv
verilog/mem2_stage.sv
verilog/mem_stage_top.sv
verification/mem_stage_tb.sv

//--- verilog/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram import lsu_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic     clk,
    input  logic     en_i,
    input  mem_req_t req_i,
    output word_t    rdata_o
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    word_t             mem [RAM_WORDS];
    word_t             rdata_q;
    logic [IDX_W-1:0]  idx;

    assign idx = req_i.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (req_i.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (req_i.sel[i]) begin
                        mem[idx][i*8 +: 8] <= req_i.data[i*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    assign rdata_o = rdata_q;

    // Request is held steady by the stalled pipe until the access fires
    a_en_with_req: assert property (@(posedge clk)
        en_i |-> req_i.ce && $stable(req_i));

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl #(
    parameter int MEM_LATENCY = 3
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic req_valid_i,
    input  logic timer_done_i,
    output logic timer_start_o,
    output logic ram_en_o,
    output logic mem_done_o,
    output logic stall_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (timer_done_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign timer_start_o = (state_q == IDLE) && req_valid_i;
    assign ram_en_o      = (state_q == WAIT) && timer_done_i;
    assign mem_done_o    = (state_q == DONE);

    // Read data is registered in DONE, so the pipe may advance on that edge
    assign stall_o = timer_start_o || (state_q == WAIT);

    // One access takes exactly MEM_LATENCY wait cycles
    a_start_seq: assert property (@(posedge clk) disable iff (!rst_n_i)
        timer_start_o |=> (state_q == WAIT) [*MEM_LATENCY] ##1 state_q == DONE);

endmodule

`default_nettype wire

//--- verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_sel_t;

    // Anything other than a memory access travels as OP_NONE
    typedef enum logic [3:0] {
        OP_NONE,
        OP_LD_B,
        OP_LD_BU,
        OP_LD_H,
        OP_LD_HU,
        OP_LD_W,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W,
        OP_LL,
        OP_SC
    } mem_op_e;

    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        addr_t     addr;
        word_t     reg2;
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
    } ex_mem_t;

    typedef struct packed {
        logic      ce;
        logic      we;
        addr_t     addr;
        byte_sel_t sel;
        word_t     data;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        logic [1:0] offset;
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        logic      sc_ok;
        logic      ale;
        mem_req_t  req;
    } mem1_mem2_t;

    typedef struct packed {
        logic      valid;
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        logic      ale;
    } wb_t;

    typedef struct packed {
        logic      is_load;
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_t;

    // LL and SC count as loads since both write a register late
    function automatic logic is_load_op(input mem_op_e op);
        return op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL, OP_SC};
    endfunction

    function automatic logic is_store_op(input mem_op_e op);
        return op inside {OP_ST_B, OP_ST_H, OP_ST_W, OP_SC};
    endfunction

endpackage

`default_nettype wire

//--- verilog/mem1_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem1_stage import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  ex_mem_t    ex_i,
    input  logic       stall_i,
    output mem1_mem2_t pipe_o,
    output fwd_t       fwd_o
);

    mem1_mem2_t pipe_d;
    mem1_mem2_t pipe_q;
    logic       llbit_q;
    logic       accept;
    logic       misaligned;
    byte_sel_t  sel;

    assign accept = ex_i.valid && !stall_i;

    // Lane select and alignment check
    always_comb begin
        misaligned = 1'b0;
        sel        = 4'b0000;
        case (ex_i.op)
            OP_LD_B, OP_LD_BU, OP_ST_B: begin
                sel = 4'b0001 << ex_i.addr[1:0];
            end
            OP_LD_H, OP_LD_HU, OP_ST_H: begin
                misaligned = ex_i.addr[0];
                sel        = ex_i.addr[1] ? 4'b1100 : 4'b0011;
            end
            OP_LD_W, OP_ST_W, OP_LL, OP_SC: begin
                misaligned = |ex_i.addr[1:0];
                sel        = 4'b1111;
            end
            default: begin
                sel = 4'b0000;
            end
        endcase
    end

    always_comb begin
        pipe_d          = '0;
        pipe_d.valid    = ex_i.valid;
        pipe_d.op       = ex_i.op;
        pipe_d.offset   = ex_i.addr[1:0];
        pipe_d.wreg     = ex_i.wreg && !misaligned;
        pipe_d.waddr    = ex_i.waddr;
        pipe_d.wdata    = ex_i.wdata;
        pipe_d.ale      = misaligned;
        pipe_d.sc_ok    = (ex_i.op == OP_SC) && llbit_q && !misaligned;
        pipe_d.req.addr = {ex_i.addr[31:2], 2'b00};
        pipe_d.req.sel  = sel;
        pipe_d.req.we   = is_store_op(ex_i.op);
        // Failed SC never reaches the memory
        pipe_d.req.ce   = (ex_i.op != OP_NONE) && !misaligned
                          && (ex_i.op != OP_SC || llbit_q);
        case (ex_i.op)
            OP_ST_B: pipe_d.req.data = {4{ex_i.reg2[7:0]}};
            OP_ST_H: pipe_d.req.data = {2{ex_i.reg2[15:0]}};
            default: pipe_d.req.data = ex_i.reg2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pipe_q  <= '0;
            llbit_q <= 1'b0;
        end else if (!stall_i) begin
            pipe_q <= accept ? pipe_d : '0;
            if (accept && !misaligned) begin
                if (ex_i.op == OP_LL) begin
                    llbit_q <= 1'b1;
                end else if (pipe_d.sc_ok) begin
                    llbit_q <= 1'b0;
                end
            end
        end
    end

    assign pipe_o = pipe_q;

    assign fwd_o.is_load = pipe_q.valid && is_load_op(pipe_q.op);
    assign fwd_o.wreg    = pipe_q.wreg;
    assign fwd_o.waddr   = pipe_q.waddr;
    assign fwd_o.wdata   = pipe_q.wdata;

    // Upstream holds a stalled request until it is accepted
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i && ex_i.valid |=> $stable(ex_i));

endmodule

`default_nettype wire

//--- verilog/mem2_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem2_stage import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  mem1_mem2_t pipe_i,
    input  logic       mem_done_i,
    input  logic       stall_i,
    input  word_t      rdata_i,
    output wb_t        wb_o
);

    logic  capture;
    word_t shifted;
    word_t result;
    wb_t   wb_q;

    // Entries without a memory request retire straight away
    assign capture = mem_done_i || (pipe_i.valid && !pipe_i.req.ce && !stall_i);

    assign shifted = rdata_i >> {pipe_i.offset, 3'b000};

    always_comb begin
        if (pipe_i.ale) begin
            result = pipe_i.wdata;
        end else begin
            case (pipe_i.op)
                OP_LD_B:         result = {{24{shifted[7]}}, shifted[7:0]};
                OP_LD_BU:        result = {24'b0, shifted[7:0]};
                OP_LD_H:         result = {{16{shifted[15]}}, shifted[15:0]};
                OP_LD_HU:        result = {16'b0, shifted[15:0]};
                OP_LD_W, OP_LL:  result = rdata_i;
                OP_SC:           result = {31'b0, pipe_i.sc_ok};
                default:         result = pipe_i.wdata;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q.valid <= capture;
            if (capture) begin
                wb_q.wreg  <= pipe_i.wreg;
                wb_q.waddr <= pipe_i.waddr;
                wb_q.wdata <= result;
                wb_q.ale   <= pipe_i.ale;
            end
        end
    end

    assign wb_o = wb_q;

    // Completion only ever belongs to an entry that asked for memory
    a_done_has_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_done_i |-> pipe_i.valid && pipe_i.req.ce);

endmodule

`default_nettype wire

//--- verilog/mem_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_top import lsu_pkg::*; #(
    parameter int MEM_LATENCY = 3,
    parameter int RAM_WORDS   = 256
) (
    input  logic    clk,
    input  logic    rst_n_i,
    input  ex_mem_t ex_i,
    output logic    stall_o,
    output wb_t     wb_o,
    output fwd_t    fwd_o
);

    mem1_mem2_t pipe;
    logic       timer_start;
    logic       timer_done;
    logic       ram_en;
    logic       mem_done;
    word_t      rdata;

    mem1_stage u_mem1 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ex_i    (ex_i),
        .stall_i (stall_o),
        .pipe_o  (pipe),
        .fwd_o   (fwd_o)
    );

    dcache_ctrl #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (pipe.req.ce),
        .timer_done_i  (timer_done),
        .timer_start_o (timer_start),
        .ram_en_o      (ram_en),
        .mem_done_o    (mem_done),
        .stall_o       (stall_o)
    );

    mem_wait_timer #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .start_i (timer_start),
        .done_o  (timer_done)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .req_i   (pipe.req),
        .rdata_o (rdata)
    );

    mem2_stage u_mem2 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pipe_i     (pipe),
        .mem_done_i (mem_done),
        .stall_i    (stall_o),
        .rdata_i    (rdata),
        .wb_o       (wb_o)
    );

endmodule

`default_nettype wire

//--- verilog/mem_wait_timer.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wait_timer #(
    parameter int MEM_LATENCY = 3
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic start_i,
    output logic done_o
);

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (start_i) begin
            count_q <= CNT_W'(MEM_LATENCY);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign done_o = (count_q == CNT_W'(1));

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n_i)
        start_i |-> count_q == '0);

endmodule

`default_nettype wire
